/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exception_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST)) mips_macros.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cp0_regs.sv */
`default_nettype none
`timescale 1ns/100ps
`include "mips_macros.svh"

module cp0_regs
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  exception_t exception,
    input  mem_stage_t stage,
    input  hw_int_t    hw_int,
    input  cp0_addr_t  raddr,
    output word_t      rdata,
    output cp0_regs_t  cp0
);

    status_t status;
    cause_t  cause;
    word_t   epc;
    word_t   badvaddr;
    status_t wr_status;
    cause_t  wr_cause;
    logic    eret;
    logic    mtc0;

    assign eret = stage.valid && stage.is_eret;
    // an excepting instruction never commits its mtc0
    assign mtc0 = stage.valid && stage.cp0_we && !exception.valid;

    // software view of the write data
    assign wr_status = status_t'(stage.cp0_wdata);
    assign wr_cause  = cause_t'(stage.cp0_wdata);

    // Status and Cause: control state, cleared by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            status <= status_t'(`STATUS_RESET);
            cause  <= '0;
        end else begin
            // hardware lines sampled every cycle
            cause.ip[`IP_HW_MSB:`IP_HW_LSB] <= hw_int;
            if (exception.valid) begin
                status.exl     <= 1'b1;
                cause.exc_code <= exception.code;
                cause.bd       <= exception.in_delay_slot;
            end else if (eret) begin
                status.exl <= 1'b0;
            end else if (mtc0) begin
                if (stage.cp0_waddr == `CP0_STATUS) begin
                    status.im  <= wr_status.im;
                    status.erl <= wr_status.erl;
                    status.exl <= wr_status.exl;
                    status.ie  <= wr_status.ie;
                end
                if (stage.cp0_waddr == `CP0_CAUSE) begin
                    // only the two software interrupt bits
                    cause.ip[1:0] <= wr_cause.ip[1:0];
                end
            end
        end
    end

    // EPC and BadVAddr carry addresses only
    always_ff @(posedge clk) begin
        if (exception.valid) begin
            // restart at the branch when the victim sits in its delay slot
            if (exception.in_delay_slot) begin
                epc <= exception.pc - 32'd4;
            end else begin
                epc <= exception.pc;
            end
            if (exception.badvaddr_valid) begin
                badvaddr <= exception.badvaddr;
            end
        end else if (mtc0 && stage.cp0_waddr == `CP0_EPC) begin
            epc <= stage.cp0_wdata;
        end
    end

    // mfc0 read port
    always_comb begin
        case (raddr)
            `CP0_STATUS:   rdata = status;
            `CP0_CAUSE:    rdata = cause;
            `CP0_EPC:      rdata = epc;
            `CP0_BADVADDR: rdata = badvaddr;
            default:       rdata = '0;
        endcase
    end

    assign cp0.status   = status;
    assign cp0.cause    = cause;
    assign cp0.epc      = epc;
    assign cp0.badvaddr = badvaddr;

endmodule

`default_nettype wire

/* exception_chk.sv */
`default_nettype none
`timescale 1ns/100ps
`include "mips_macros.svh"

module exception_chk
    import mips_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input mem_stage_t stage,
    input exception_t exception,
    input cp0_regs_t  cp0,
    input word_t      pc,
    input logic       flush
);

    int unsigned fail_count = 0;
    logic        eret_taken;

    // an exception in the same cycle wins over eret
    assign eret_taken = stage.valid && stage.is_eret && !exception.valid;

    a_flush_on_exc: assert property (@(posedge clk) exception.valid |-> flush)
        else begin
            $error("flush low in an exception cycle");
            fail_count++;
        end

    a_vector: assert property (@(posedge clk) disable iff (reset)
        exception.valid |=> (pc == `EXC_ENTRY) && cp0.status.exl)
        else begin
            $error("pc or Status.EXL wrong after exception entry");
            fail_count++;
        end

    a_eret_return: assert property (@(posedge clk) disable iff (reset)
        eret_taken |=> pc == $past(cp0.epc))
        else begin
            $error("pc does not match EPC after eret");
            fail_count++;
        end

    a_reset_quiet: assert property (@(posedge clk) reset |-> !exception.valid)
        else begin
            $error("exception raised during reset");
            fail_count++;
        end

endmodule

bind exception_top exception_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .stage     (stage),
    .exception (exception),
    .cp0       (cp0),
    .pc        (pc),
    .flush     (flush)
);

`default_nettype wire

/* exception_top.sv */
`default_nettype none
`timescale 1ns/100ps

module exception_top
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  mem_stage_t stage,
    input  hw_int_t    hw_int,
    input  logic       branch_taken,
    input  word_t      branch_target,
    input  logic       stall,
    input  cp0_addr_t  cp0_raddr,
    output word_t      pc,
    output logic       flush,
    output word_t      cp0_rdata,
    output exception_t exception
);

    cp0_regs_t cp0;

    exception_unit u_exception_unit (
        .stage     (stage),
        .cp0       (cp0),
        .reset     (reset),
        .exception (exception)
    );

    cp0_regs u_cp0_regs (
        .clk       (clk),
        .reset     (reset),
        .exception (exception),
        .stage     (stage),
        .hw_int    (hw_int),
        .raddr     (cp0_raddr),
        .rdata     (cp0_rdata),
        .cp0       (cp0)
    );

    // eret counts only for a real instruction
    pc_select u_pc_select (
        .clk           (clk),
        .reset         (reset),
        .exception     (exception),
        .eret          (stage.valid && stage.is_eret),
        .epc           (cp0.epc),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .stall         (stall),
        .pc            (pc),
        .flush         (flush)
    );

endmodule

`default_nettype wire

/* exception_unit.sv */
`default_nettype none
`timescale 1ns/100ps
`include "mips_macros.svh"

module exception_unit
    import mips_pkg::*;
(
    input  mem_stage_t stage,
    input  cp0_regs_t  cp0,
    input  logic       reset,
    output exception_t exception
);

    logic [7:0] int_pending;
    logic       int_valid;
    logic       exc_hit;
    exc_code_t  exc_code;
    logic       badvaddr_valid;
    word_t      badvaddr;

    // unmasked requests, taken only at base level with IE set
    assign int_pending = cp0.cause.ip & cp0.status.im;
    assign int_valid = (int_pending != 8'h00)
                     && cp0.status.ie
                     && !cp0.status.exl
                     && !cp0.status.erl;

    // highest priority first
    always_comb begin
        exc_hit        = 1'b1;
        exc_code       = `CODE_INT;
        badvaddr_valid = 1'b0;
        badvaddr       = stage.vaddr;
        if (int_valid) begin
            exc_code = `CODE_INT;
        end else if (stage.flags.instr_adel) begin
            exc_code       = `CODE_ADEL;
            badvaddr_valid = 1'b1;
            // fetch error, the faulting address is the pc itself
            badvaddr       = stage.pc;
        end else if (stage.flags.ri) begin
            exc_code = `CODE_RI;
        end else if (stage.flags.ov) begin
            exc_code = `CODE_OV;
        end else if (stage.flags.sys) begin
            exc_code = `CODE_SYS;
        end else if (stage.flags.bp) begin
            exc_code = `CODE_BP;
        end else if (stage.flags.data_adel) begin
            exc_code       = `CODE_ADEL;
            badvaddr_valid = 1'b1;
        end else if (stage.flags.data_ades) begin
            exc_code       = `CODE_ADES;
            badvaddr_valid = 1'b1;
        end else begin
            exc_hit = 1'b0;
        end
    end

    // bubbles never raise anything, interrupts wait for a real instruction
    assign exception.valid          = stage.valid && exc_hit && !reset;
    assign exception.code           = exc_code;
    assign exception.pc             = stage.pc;
    assign exception.in_delay_slot  = stage.in_delay_slot;
    assign exception.badvaddr_valid = badvaddr_valid;
    assign exception.badvaddr       = badvaddr;

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
mips_pkg.sv
exception_unit.sv
cp0_regs.sv
pc_select.sv
exception_top.sv
exception_chk.sv
tb_clock_gen.sv
tb_exception_top.sv

/* mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Cause.ExcCode values
`define CODE_INT        5'd0
`define CODE_ADEL       5'd4
`define CODE_ADES       5'd5
`define CODE_SYS        5'd8
`define CODE_BP         5'd9
`define CODE_RI         5'd10
`define CODE_OV         5'd12

// single exception vector, no BEV or EXL offsets
`define EXC_ENTRY       32'hBFC0_0380

// first fetch address out of reset
`define RESET_PC        32'hBFC0_0000

// CP0 register numbers seen by mtc0/mfc0
`define CP0_BADVADDR    5'd8
`define CP0_STATUS      5'd12
`define CP0_CAUSE       5'd13
`define CP0_EPC         5'd14

// Status after reset
// BEV (bit 22) reads as 1 but has no effect, since the vector is fixed.
// ERL, EXL and IE are clear, so interrupts stay off until software sets IE.
`define STATUS_RESET    32'h0040_0000

// bit positions in the packed Status word, for field access by number
`define STATUS_IE_BIT   0
`define STATUS_EXL_BIT  1
`define STATUS_ERL_BIT  2

// Cause.IP bits owned by hardware lines
`define IP_HW_LSB       2
`define IP_HW_MSB       7

`endif

/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [4:0]  cp0_addr_t;
    typedef logic [5:0]  hw_int_t;

    // Status, MIPS32 bit layout
    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  im;
        logic [4:0]  rsvd_lo;
        logic        erl;
        logic        exl;
        logic        ie;
    } status_t;

    // Cause, MIPS32 bit layout
    typedef struct packed {
        logic        bd;
        logic [14:0] rsvd_hi;
        logic [7:0]  ip;
        logic        rsvd_mid;
        exc_code_t   exc_code;
        logic [1:0]  rsvd_lo;
    } cause_t;

    typedef struct packed {
        status_t status;
        cause_t  cause;
        word_t   epc;
        word_t   badvaddr;
    } cp0_regs_t;

    // exception flags raised by earlier stages
    typedef struct packed {
        logic instr_adel;
        logic ri;
        logic ov;
        logic sys;
        logic bp;
        logic data_adel;
        logic data_ades;
    } exc_flags_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        logic       in_delay_slot;
        word_t      vaddr;
        exc_flags_t flags;
        logic       is_eret;
        logic       cp0_we;
        cp0_addr_t  cp0_waddr;
        word_t      cp0_wdata;
    } mem_stage_t;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
        word_t     pc;
        logic      in_delay_slot;
        logic      badvaddr_valid;
        word_t     badvaddr;
    } exception_t;

endpackage

`default_nettype wire

/* pc_select.sv */
`default_nettype none
`timescale 1ns/100ps
`include "mips_macros.svh"

module pc_select
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  exception_t exception,
    input  logic       eret,
    input  word_t      epc,
    input  logic       branch_taken,
    input  word_t      branch_target,
    input  logic       stall,
    output word_t      pc,
    output logic       flush
);

    word_t pc_seq;

    // sequential path, branch beats fall-through
    assign pc_seq = branch_taken ? branch_target : pc + 32'd4;

    // redirects are taken even while the front end is stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (exception.valid) begin
            pc <= `EXC_ENTRY;
        end else if (eret) begin
            pc <= epc;
        end else if (!stall) begin
            pc <= pc_seq;
        end
    end

    // kill the younger instructions behind the memory stage
    assign flush = exception.valid || eret;

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
    end

    always #(period_ns / 2) clk = ~clk;

    // reset released on a rising edge, like any other input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb_exception_top.sv */
`default_nettype none
`timescale 1ns/100ps
`include "mips_macros.svh"

module tb_exception_top
    import mips_pkg::*;
();

    // about 60 cycles per test for five tests plus margin
    localparam int unsigned timeout_cycles = 400;

    logic       clk;
    logic       reset;
    mem_stage_t stage;
    hw_int_t    hw_int;
    logic       branch_taken;
    word_t      branch_target;
    logic       stall;
    cp0_addr_t  cp0_raddr;
    word_t      pc;
    logic       flush;
    word_t      cp0_rdata;
    exception_t exception;

    integer      seed = 32'h891c_b98f;
    int unsigned cycle_count = 0;
    int unsigned chk_base = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          error_count = 0;
    int          test_errors = 0;

    tb_clock_gen #(.period_ns(40), .reset_cycles(2)) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    exception_top u_dut (
        .clk           (clk),
        .reset         (reset),
        .stage         (stage),
        .hw_int        (hw_int),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .stall         (stall),
        .cp0_raddr     (cp0_raddr),
        .pc            (pc),
        .flush         (flush),
        .cp0_rdata     (cp0_rdata),
        .exception     (exception)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // expected code for the stage flags alone
    function automatic exc_code_t expected_code(input exc_flags_t f);
        if (f.instr_adel)
            return `CODE_ADEL;
        if (f.ri)
            return `CODE_RI;
        if (f.ov)
            return `CODE_OV;
        if (f.sys)
            return `CODE_SYS;
        if (f.bp)
            return `CODE_BP;
        if (f.data_adel)
            return `CODE_ADEL;
        return `CODE_ADES;
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic begin_test();
        test_errors = 0;
        chk_base = u_dut.u_chk.fail_count;
    endtask

    task automatic end_test(input string name);
        int unsigned assert_fails;
        assert_fails = u_dut.u_chk.fail_count - chk_base;
        tests_run++;
        error_count += test_errors;
        if (test_errors != 0 || assert_fails != 0) begin
            tests_failed++;
            $display("test %s: failed, %0d value errors, %0d assertion failures",
                     name, test_errors, assert_fails);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // mfc0 with a bubble in the memory stage
    task automatic read_cp0(input cp0_addr_t addr, output word_t value);
        @(posedge clk);
        stage <= '0;
        cp0_raddr <= addr;
        @(negedge clk);
        value = cp0_rdata;
    endtask

    // mtc0 to Status followed by one plain instruction as an interrupt probe
    task automatic status_write_probe(input word_t wdata, input logic int_expected);
        mem_stage_t w;
        w = '0;
        w.valid = 1'b1;
        w.cp0_we = 1'b1;
        w.cp0_waddr = `CP0_STATUS;
        w.cp0_wdata = wdata;
        @(posedge clk);
        stage <= w;
        @(negedge clk);
        check("exception.valid", word_t'(exception.valid), 32'd0);
        w.cp0_we = 1'b0;
        @(posedge clk);
        stage <= w;
        @(negedge clk);
        check("exception.valid", word_t'(exception.valid), word_t'(int_expected));
    endtask

    initial begin
        word_t      rd;
        word_t      rnd;
        logic       addr_err;
        mem_stage_t s;
        int         lvl;
        // excepting instruction held in the stage during reset
        stage = '0;
        stage.valid = 1'b1;
        stage.flags.sys = 1'b1;
        hw_int = '0;
        branch_taken = 1'b0;
        branch_target = '0;
        stall = 1'b1;
        cp0_raddr = '0;
        wait (!reset);
        stage <= '0;
        @(negedge clk);

        begin_test();
        check("pc", pc, `RESET_PC);
        check("flush", word_t'(flush), 32'd0);
        read_cp0(`CP0_STATUS, rd);
        check("status", rd, `STATUS_RESET);
        end_test("reset_state");

        begin_test();
        for (int i = 0; i < 12; i++) begin
            rnd = $random(seed);
            lvl = i % 7;
            s = '0;
            s.valid = 1'b1;
            // flag at level i % 7 is the highest one set
            s.flags = exc_flags_t'((rnd[6:0] & (7'h7f >> lvl)) | (7'h40 >> lvl));
            s.in_delay_slot = i[0];
            rnd = $random(seed);
            s.pc = {rnd[31:2], 2'b00};
            s.vaddr = $random(seed);
            @(posedge clk);
            stage <= s;
            @(negedge clk);
            check("exception.valid", word_t'(exception.valid), 32'd1);
            check("exception.code", word_t'(exception.code), word_t'(expected_code(s.flags)));
            read_cp0(`CP0_EPC, rd);
            check("epc", rd, s.in_delay_slot ? s.pc - 32'd4 : s.pc);
            addr_err = s.flags.instr_adel
                || !(s.flags.ri || s.flags.ov || s.flags.sys || s.flags.bp);
            if (addr_err) begin
                read_cp0(`CP0_BADVADDR, rd);
                check("badvaddr", rd, s.flags.instr_adel ? s.pc : s.vaddr);
            end
        end
        end_test("exception_priority");

        begin_test();
        s = '0;
        s.valid = 1'b1;
        s.pc = 32'h0040_1230;
        s.flags.sys = 1'b1;
        @(posedge clk);
        stage <= s;
        @(negedge clk);
        check("flush", word_t'(flush), 32'd1);
        s = '0;
        s.valid = 1'b1;
        s.is_eret = 1'b1;
        @(posedge clk);
        stage <= s;
        @(negedge clk);
        check("pc", pc, `EXC_ENTRY);
        check("flush", word_t'(flush), 32'd1);
        read_cp0(`CP0_STATUS, rd);
        check("pc", pc, 32'h0040_1230);
        check("status", rd, `STATUS_RESET);
        @(negedge clk);
        end_test("vector_and_eret");

        begin_test();
        @(posedge clk);
        hw_int <= 6'b00_0001;
        @(posedge clk);
        // blocked by IE, by IM and by EXL before the line gets through
        status_write_probe(32'h0000_0400, 1'b0);
        status_write_probe(32'h0000_0001, 1'b0);
        status_write_probe(32'h0000_0403, 1'b0);
        status_write_probe(32'h0000_0401, 1'b1);
        check("exception.code", word_t'(exception.code), word_t'(`CODE_INT));
        @(posedge clk);
        hw_int <= '0;
        read_cp0(`CP0_CAUSE, rd);
        check("cause.exc_code", word_t'(rd[6:2]), word_t'(`CODE_INT));
        end_test("interrupt_masking");

        begin_test();
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        rd = pc;
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        check("pc", pc, rd + 32'd4);
        rd = pc;
        @(posedge clk);
        @(negedge clk);
        check("pc", pc, rd);
        rnd = $random(seed);
        @(posedge clk);
        stall <= 1'b0;
        branch_taken <= 1'b1;
        branch_target <= {rnd[31:2], 2'b00};
        @(posedge clk);
        stall <= 1'b1;
        branch_taken <= 1'b0;
        @(negedge clk);
        check("pc", pc, {rnd[31:2], 2'b00});
        s = '0;
        s.valid = 1'b1;
        s.flags.bp = 1'b1;
        @(posedge clk);
        stage <= s;
        @(posedge clk);
        stage <= '0;
        @(negedge clk);
        check("pc", pc, `EXC_ENTRY);
        @(negedge clk);
        end_test("ordinary_flow");

        $display("tests run %0d, failed %0d, value errors %0d, assertion failures %0d",
                 tests_run, tests_failed, error_count, u_dut.u_chk.fail_count);
        if (tests_failed == 0 && u_dut.u_chk.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
